/* source/apb_bridge_params.svh */
// APB bridge parameters

`ifndef APB_BRIDGE_PARAMS_SVH
`define APB_BRIDGE_PARAMS_SVH

// Slave map
`define APB_NUM_SLAVES 3                 // Real slaves, default slave not counted
`define APB_MAP_BASE   32'h1000_0000     // Base of slave 0
`define APB_SLOT_SIZE  32'h0000_1000     // Bytes per slave window

// Data path widths
`define APB_ADDR_W     32
`define APB_DATA_W     32                // APB side
`define BUS_DATA_W     64                // System-bus side

// Slave index must also encode the default slave
`define APB_SEL_W      2

// Derived strobe widths
`define APB_STRB_W     (`APB_DATA_W / 8)
`define BUS_STRB_W     (`BUS_DATA_W / 8)

`endif

/* source/apb_bridge_pkg.sv */
// APB bridge types

`include "apb_bridge_params.svh"

package apb_bridge_pkg;

    // Byte address on both sides
    typedef logic [`APB_ADDR_W-1:0] addr_t;

    // APB data path
    typedef logic [`APB_DATA_W-1:0] apb_data_t;
    typedef logic [`APB_STRB_W-1:0] apb_strb_t;

    // System-bus data path
    typedef logic [`BUS_DATA_W-1:0] bus_data_t;
    typedef logic [`BUS_STRB_W-1:0] bus_strb_t;

    typedef logic [7:0] req_size_t;      // Request size in bytes

    // Value APB_NUM_SLAVES selects the default slave
    typedef logic [`APB_SEL_W-1:0] sel_idx_t;

    // Transfer sequencer states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,    // Waiting for a request
        ST_SETUP  = 2'd1,    // psel high, penable low
        ST_ACCESS = 2'd2,    // penable high until pready
        ST_OUT    = 2'd3     // Response cycle
    } seq_state_t;

endpackage

/* source/apb_master_if.sv */
// APB master signal bundle

`include "apb_bridge_params.svh"

interface apb_master_if;

    // Driven by the sequencer
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   pwrite;
    logic [`APB_DATA_W-1:0] pwdata;
    logic [`APB_STRB_W-1:0] pstrb;
    logic                   psel;
    logic                   penable;

    // Driven back by the fabric
    logic                   pready;
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pslverr;

    modport master (
        output paddr, pwrite, pwdata, pstrb, psel, penable,
        input  pready, prdata, pslverr
    );

    modport fabric (
        input  paddr, pwrite, pwdata, pstrb, psel, penable,
        output pready, prdata, pslverr
    );

endinterface

/* source/apb_addr_decoder.sv */
// APB slave address decoder

`include "apb_bridge_params.svh"

module apb_addr_decoder (
    input  logic                      i_clk,
    input  logic                      i_nrst,
    input  apb_bridge_pkg::addr_t     i_req_addr,
    input  logic                      i_accept,     // Request taken by the sequencer
    output apb_bridge_pkg::sel_idx_t  o_sel_idx
);

    apb_bridge_pkg::sel_idx_t sel_next;
    apb_bridge_pkg::sel_idx_t sel_q;

    // Window match, falls back to the default slave
    always_comb begin
        apb_bridge_pkg::addr_t slot_lo;
        apb_bridge_pkg::addr_t slot_hi;

        sel_next = apb_bridge_pkg::sel_idx_t'(`APB_NUM_SLAVES);
        for (int i = 0; i < `APB_NUM_SLAVES; i++) begin
            slot_lo = `APB_MAP_BASE + apb_bridge_pkg::addr_t'(i) * `APB_SLOT_SIZE;
            slot_hi = slot_lo + `APB_SLOT_SIZE;
            if ((i_req_addr >= slot_lo) && (i_req_addr < slot_hi)) begin
                sel_next = apb_bridge_pkg::sel_idx_t'(i);
            end
        end
    end

    // Held for the whole transaction
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            sel_q <= apb_bridge_pkg::sel_idx_t'(`APB_NUM_SLAVES);
        end else if (i_accept) begin
            sel_q <= sel_next;
        end
    end

    assign o_sel_idx = sel_q;

endmodule

/* source/apb_transfer_seq.sv */
// APB transfer sequencer

module apb_transfer_seq (
    input  logic                       i_clk,
    input  logic                       i_nrst,
    // Request side
    input  logic                       i_req_valid,
    input  apb_bridge_pkg::addr_t      i_req_addr,
    input  apb_bridge_pkg::req_size_t  i_req_size,
    input  logic                       i_req_write,
    input  apb_bridge_pkg::bus_data_t  i_req_wdata,
    input  apb_bridge_pkg::bus_strb_t  i_req_wstrb,
    input  logic                       i_req_last,
    output logic                       o_req_ready,
    output logic                       o_accept,      // One cycle, to the decoder
    // Response side
    output logic                       o_resp_valid,
    output apb_bridge_pkg::bus_data_t  o_resp_rdata,
    output logic                       o_resp_err,
    // APB master
    apb_master_if.master               m
);

    apb_bridge_pkg::seq_state_t state_q;

    // Control registers
    logic                       psel_q;
    logic                       penable_q;
    logic                       pwrite_q;
    logic                       resp_valid_q;
    logic                       err_q;
    apb_bridge_pkg::req_size_t  size_q;      // Bytes still to transfer

    // Payload registers
    apb_bridge_pkg::addr_t      paddr_q;
    apb_bridge_pkg::apb_data_t  pwdata_q;
    apb_bridge_pkg::apb_strb_t  pstrb_q;
    apb_bridge_pkg::apb_data_t  wdata_hi_q;  // Upper lane kept for the second word
    apb_bridge_pkg::apb_strb_t  wstrb_hi_q;
    apb_bridge_pkg::bus_data_t  rdata_q;

    assign o_req_ready = (state_q == apb_bridge_pkg::ST_IDLE);
    assign o_accept    = o_req_ready && i_req_valid && i_req_last;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q      <= apb_bridge_pkg::ST_IDLE;
            psel_q       <= 1'b0;
            penable_q    <= 1'b0;
            pwrite_q     <= 1'b0;
            resp_valid_q <= 1'b0;
            err_q        <= 1'b0;
            size_q       <= '0;
        end else begin
            resp_valid_q <= 1'b0;
            case (state_q)
                apb_bridge_pkg::ST_IDLE: begin
                    if (i_req_valid) begin
                        pwrite_q <= i_req_write;
                        size_q   <= i_req_size;
                        if (i_req_last) begin
                            psel_q  <= 1'b1;
                            err_q   <= 1'b0;
                            state_q <= apb_bridge_pkg::ST_SETUP;
                        end else begin
                            // Bursts are refused without APB traffic
                            err_q        <= 1'b1;
                            resp_valid_q <= 1'b1;
                            state_q      <= apb_bridge_pkg::ST_OUT;
                        end
                    end
                end
                apb_bridge_pkg::ST_SETUP: begin
                    penable_q <= 1'b1;
                    state_q   <= apb_bridge_pkg::ST_ACCESS;
                end
                apb_bridge_pkg::ST_ACCESS: begin
                    if (m.pready) begin
                        penable_q <= 1'b0;
                        err_q     <= m.pslverr;      // Last word's error wins
                        if (size_q > 8'd4) begin
                            size_q  <= size_q - 8'd4;
                            state_q <= apb_bridge_pkg::ST_SETUP;
                        end else begin
                            psel_q       <= 1'b0;
                            pwrite_q     <= 1'b0;
                            resp_valid_q <= 1'b1;
                            state_q      <= apb_bridge_pkg::ST_OUT;
                        end
                    end
                end
                default: state_q <= apb_bridge_pkg::ST_IDLE;   // ST_OUT
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_req_ready && i_req_valid) begin
            paddr_q    <= i_req_addr & ~apb_bridge_pkg::addr_t'(3);  // Word aligned
            wdata_hi_q <= i_req_wdata[63:32];
            wstrb_hi_q <= i_req_wstrb[7:4];
            rdata_q    <= '1;
            if (i_req_addr[2]) begin
                pwdata_q <= i_req_wdata[63:32];
                pstrb_q  <= i_req_wstrb[7:4];
            end else begin
                pwdata_q <= i_req_wdata[31:0];
                pstrb_q  <= i_req_wstrb[3:0];
            end
        end else if ((state_q == apb_bridge_pkg::ST_ACCESS) && m.pready) begin
            // Read data lands in the half chosen by address bit 2
            if (paddr_q[2]) begin
                rdata_q[63:32] <= m.prdata;
            end else begin
                rdata_q[31:0] <= m.prdata;
            end
            if (size_q > 8'd4) begin
                paddr_q  <= paddr_q + apb_bridge_pkg::addr_t'(4);
                pwdata_q <= wdata_hi_q;
                pstrb_q  <= wstrb_hi_q;
            end
        end
    end

    assign m.paddr   = paddr_q;
    assign m.pwrite  = pwrite_q;
    assign m.pwdata  = pwdata_q;
    assign m.pstrb   = pstrb_q;
    assign m.psel    = psel_q;
    assign m.penable = penable_q;

    assign o_resp_valid = resp_valid_q;
    assign o_resp_rdata = rdata_q;
    assign o_resp_err   = err_q;

endmodule

/* source/apb_slave_fabric.sv */
// APB slave routing fabric

`include "apb_bridge_params.svh"

module apb_slave_fabric (
    input  apb_bridge_pkg::sel_idx_t                i_sel_idx,
    apb_master_if.fabric                            m,
    output logic [`APB_NUM_SLAVES-1:0]              o_psel,
    input  logic [`APB_NUM_SLAVES-1:0]              i_pready,
    input  logic [`APB_NUM_SLAVES-1:0][`APB_DATA_W-1:0] i_prdata,
    input  logic [`APB_NUM_SLAVES-1:0]              i_pslverr
);

    logic                   sel_mapped;   // Index points at a real slave
    logic                   rsp_ready;
    logic                   rsp_err;
    logic [`APB_DATA_W-1:0] rsp_data;

    assign sel_mapped = (i_sel_idx < `APB_NUM_SLAVES);

    // One-hot select, only while the master drives psel
    always_comb begin
        for (int i = 0; i < `APB_NUM_SLAVES; i++) begin
            o_psel[i] = m.psel && (i_sel_idx == apb_bridge_pkg::sel_idx_t'(i));
        end
    end

    // Reply mux
    always_comb begin
        // Default slave answers at once with an error
        rsp_ready = 1'b1;
        rsp_err   = 1'b1;
        rsp_data  = '1;
        if (sel_mapped) begin
            for (int i = 0; i < `APB_NUM_SLAVES; i++) begin
                if (i_sel_idx == apb_bridge_pkg::sel_idx_t'(i)) begin
                    rsp_ready = i_pready[i];
                    rsp_err   = i_pslverr[i];
                    rsp_data  = i_prdata[i];
                end
            end
        end
    end

    assign m.pready  = rsp_ready;
    assign m.pslverr = rsp_err;
    assign m.prdata  = rsp_data;

endmodule

/* source/apb_bridge_top.sv */
// Request to APB bridge

`include "apb_bridge_params.svh"

module apb_bridge_top (
    input  logic                                    i_clk,
    input  logic                                    i_nrst,
    // Request port
    input  logic                                    i_req_valid,
    input  logic [`APB_ADDR_W-1:0]                  i_req_addr,
    input  logic [7:0]                              i_req_size,
    input  logic                                    i_req_write,
    input  logic [`BUS_DATA_W-1:0]                  i_req_wdata,
    input  logic [`BUS_STRB_W-1:0]                  i_req_wstrb,
    input  logic                                    i_req_last,
    output logic                                    o_req_ready,
    // Response
    output logic                                    o_resp_valid,
    output logic [`BUS_DATA_W-1:0]                  o_resp_rdata,
    output logic                                    o_resp_err,
    // APB slaves
    output logic [`APB_ADDR_W-1:0]                  o_paddr,
    output logic                                    o_pwrite,
    output logic [`APB_DATA_W-1:0]                  o_pwdata,
    output logic [`APB_STRB_W-1:0]                  o_pstrb,
    output logic                                    o_penable,
    output logic [`APB_NUM_SLAVES-1:0]              o_psel,
    input  logic [`APB_NUM_SLAVES-1:0]              i_pready,
    input  logic [`APB_NUM_SLAVES-1:0][`APB_DATA_W-1:0] i_prdata,
    input  logic [`APB_NUM_SLAVES-1:0]              i_pslverr
);

    logic                  accept;
    logic [`APB_SEL_W-1:0] sel_idx;

    apb_master_if apb_if ();

    apb_addr_decoder apb_addr_decoder_i (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_req_addr (i_req_addr),
        .i_accept   (accept),
        .o_sel_idx  (sel_idx)
    );

    apb_transfer_seq apb_transfer_seq_i (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req_addr   (i_req_addr),
        .i_req_size   (i_req_size),
        .i_req_write  (i_req_write),
        .i_req_wdata  (i_req_wdata),
        .i_req_wstrb  (i_req_wstrb),
        .i_req_last   (i_req_last),
        .o_req_ready  (o_req_ready),
        .o_accept     (accept),
        .o_resp_valid (o_resp_valid),
        .o_resp_rdata (o_resp_rdata),
        .o_resp_err   (o_resp_err),
        .m            (apb_if.master)
    );

    apb_slave_fabric apb_slave_fabric_i (
        .i_sel_idx (sel_idx),
        .m         (apb_if.fabric),
        .o_psel    (o_psel),
        .i_pready  (i_pready),
        .i_prdata  (i_prdata),
        .i_pslverr (i_pslverr)
    );

    // Shared APB fields go to every slave
    assign o_paddr   = apb_if.paddr;
    assign o_pwrite  = apb_if.pwrite;
    assign o_pwdata  = apb_if.pwdata;
    assign o_pstrb   = apb_if.pstrb;
    assign o_penable = apb_if.penable;

endmodule

/* verif/apb_slave_model.sv */
// APB slave bank model

`include "apb_bridge_params.svh"

module apb_slave_model (
    input  logic                                        i_clk,
    input  logic                                        i_nrst,
    input  logic [`APB_ADDR_W-1:0]                      i_paddr,
    input  logic                                        i_pwrite,
    input  logic [`APB_DATA_W-1:0]                      i_pwdata,
    input  logic [`APB_STRB_W-1:0]                      i_pstrb,
    input  logic                                        i_penable,
    input  logic [`APB_NUM_SLAVES-1:0]                  i_psel,
    output logic [`APB_NUM_SLAVES-1:0]                  o_pready,
    output logic [`APB_NUM_SLAVES-1:0][`APB_DATA_W-1:0] o_prdata,
    output logic [`APB_NUM_SLAVES-1:0]                  o_pslverr
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`APB_DATA_W-1:0] mem [`APB_NUM_SLAVES][1024];
    logic [1:0]             wait_cnt [`APB_NUM_SLAVES];
    logic [9:0]             word;

    assign word = i_paddr[11:2];    // Word offset within the slot

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    initial begin
        for (int s = 0; s < `APB_NUM_SLAVES; s++) begin
            for (int w = 0; w < 1024; w++) begin
                mem[s][w] = fill_word(`APB_MAP_BASE + s * `APB_SLOT_SIZE + w * 4);
            end
        end
    end

    always @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int s = 0; s < `APB_NUM_SLAVES; s++) begin
                wait_cnt[s] <= 2'd0;
            end
        end else begin
            for (int s = 0; s < `APB_NUM_SLAVES; s++) begin
                if (i_psel[s] && !i_penable) begin
                    wait_cnt[s] <= 2'($urandom);    // 0 to 3 wait states per transfer
                end else if (i_psel[s] && i_penable) begin
                    if (wait_cnt[s] != 2'd0) begin
                        wait_cnt[s] <= wait_cnt[s] - 2'd1;
                    end else if (i_pwrite && !o_pslverr[s]) begin
                        for (int b = 0; b < `APB_STRB_W; b++) begin
                            if (i_pstrb[b]) begin
                                mem[s][word][8*b +: 8] <= i_pwdata[8*b +: 8];
                            end
                        end
                    end
                end
            end
        end
    end

    for (genvar s = 0; s < `APB_NUM_SLAVES; s++) begin : g_slave
        assign o_pready[s]  = (wait_cnt[s] == 2'd0);
        assign o_pslverr[s] = (word >= 10'h3fc);     // Top four words of each slot
        assign o_prdata[s]  = mem[s][word];
    end

endmodule

/* verif/apb_bridge_tb.sv */
// APB bridge testbench

`include "apb_bridge_params.svh"

module apb_bridge_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQS    = 400;
    localparam int RESET_CYC   = 16;
    localparam int CYCLE_LIMIT = NUM_REQS * 40 + RESET_CYC;

    logic                                        clk;
    logic                                        nrst;
    logic                                        req_valid;
    apb_bridge_pkg::addr_t                       req_addr;
    apb_bridge_pkg::req_size_t                   req_size;
    logic                                        req_write;
    apb_bridge_pkg::bus_data_t                   req_wdata;
    apb_bridge_pkg::bus_strb_t                   req_wstrb;
    logic                                        req_last;
    logic                                        req_ready;
    logic                                        resp_valid;
    apb_bridge_pkg::bus_data_t                   resp_rdata;
    logic                                        resp_err;
    apb_bridge_pkg::addr_t                       paddr;
    logic                                        pwrite;
    apb_bridge_pkg::apb_data_t                   pwdata;
    apb_bridge_pkg::apb_strb_t                   pstrb;
    logic                                        penable;
    logic [`APB_NUM_SLAVES-1:0]                  psel;
    logic [`APB_NUM_SLAVES-1:0]                  pready;
    logic [`APB_NUM_SLAVES-1:0][`APB_DATA_W-1:0] prdata;
    logic [`APB_NUM_SLAVES-1:0]                  pslverr;

    apb_bridge_pkg::apb_data_t model_mem [`APB_NUM_SLAVES][1024];   // Mirror of the slave bank
    int                        cycles;

    apb_bridge_top apb_bridge_top_i (
        .i_clk        (clk),
        .i_nrst       (nrst),
        .i_req_valid  (req_valid),
        .i_req_addr   (req_addr),
        .i_req_size   (req_size),
        .i_req_write  (req_write),
        .i_req_wdata  (req_wdata),
        .i_req_wstrb  (req_wstrb),
        .i_req_last   (req_last),
        .o_req_ready  (req_ready),
        .o_resp_valid (resp_valid),
        .o_resp_rdata (resp_rdata),
        .o_resp_err   (resp_err),
        .o_paddr      (paddr),
        .o_pwrite     (pwrite),
        .o_pwdata     (pwdata),
        .o_pstrb      (pstrb),
        .o_penable    (penable),
        .o_psel       (psel),
        .i_pready     (pready),
        .i_prdata     (prdata),
        .i_pslverr    (pslverr)
    );

    apb_slave_model apb_slave_model_i (
        .i_clk     (clk),
        .i_nrst    (nrst),
        .i_paddr   (paddr),
        .i_pwrite  (pwrite),
        .i_pwdata  (pwdata),
        .i_pstrb   (pstrb),
        .i_penable (penable),
        .i_psel    (psel),
        .o_pready  (pready),
        .o_prdata  (prdata),
        .o_pslverr (pslverr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run($sformatf("Run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic is_mapped(input apb_bridge_pkg::addr_t a);
        return (a >= `APB_MAP_BASE) && (a < `APB_MAP_BASE + `APB_NUM_SLAVES * `APB_SLOT_SIZE);
    endfunction

    function automatic int slave_of(input apb_bridge_pkg::addr_t a);
        return int'((a - `APB_MAP_BASE) / `APB_SLOT_SIZE);
    endfunction

    // Select vector the window map expects for an address
    function automatic logic [`APB_NUM_SLAVES-1:0] window_sel(input apb_bridge_pkg::addr_t a);
        if (!is_mapped(a)) begin
            return '0;
        end
        return 1 << slave_of(a);
    endfunction

    function automatic void store_word(input int s, input int w,
                                       input apb_bridge_pkg::apb_data_t data,
                                       input apb_bridge_pkg::apb_strb_t strb);
        if (w >= 'h3fc) begin
            return;     // Error words keep their contents
        end
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                model_mem[s][w][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    // Shared APB fields in access phase number idx of a request
    task automatic check_access(input apb_bridge_pkg::addr_t addr, input logic write,
                                input apb_bridge_pkg::bus_data_t wdata,
                                input apb_bridge_pkg::bus_strb_t wstrb, input int idx);
        logic upper;

        upper = addr[2] || (idx > 0);   // Second word and odd words use the upper lanes
        check_hex("o_paddr", paddr, {addr[31:2], 2'b00} + 32'(4 * idx));
        check_hex("o_pwrite", pwrite, write);
        if (write) begin
            check_hex("o_pwdata", pwdata, upper ? wdata[63:32] : wdata[31:0]);
            check_hex("o_pstrb", pstrb, upper ? wstrb[7:4] : wstrb[3:0]);
        end
    endtask

    // Called on a rising edge; returns on the edge that samples the response
    task automatic run_request(input apb_bridge_pkg::addr_t addr,
                               input apb_bridge_pkg::req_size_t size, input logic write,
                               input apb_bridge_pkg::bus_data_t wdata,
                               input apb_bridge_pkg::bus_strb_t wstrb, input logic last);
        int                         lat;
        int                         s;
        int                         w;
        int                         xfers;      // Access phases seen
        logic                       pen_d;      // penable on the previous edge
        logic [`APB_NUM_SLAVES-1:0] psel_seen;
        logic                       apb_seen;
        logic                       exp_err;
        apb_bridge_pkg::bus_data_t  exp_data;
        apb_bridge_pkg::bus_data_t  mask;

        #1;
        req_valid = 1'b1;
        req_addr  = addr;
        req_size  = size;
        req_write = write;
        req_wdata = wdata;
        req_wstrb = wstrb;
        req_last  = last;
        do @(posedge clk); while (!req_ready);
        #1;
        req_valid = 1'b0;
        lat       = 0;
        xfers     = 0;
        pen_d     = 1'b0;
        psel_seen = '0;
        apb_seen  = 1'b0;
        do begin
            @(posedge clk);
            lat++;
            if (penable) begin
                if (!pen_d) begin
                    xfers++;
                end
                check_hex("o_psel", psel, window_sel(paddr));
                check_access(addr, write, wdata, wstrb, xfers - 1);
            end
            pen_d      = penable;
            psel_seen |= psel;
            apb_seen  |= penable | (|psel);
        end while (!resp_valid);

        if (last) begin
            assert (xfers == ((size == 8'd8) ? 2 : 1)) else begin
                fail_run($sformatf("Request of %0d bytes made %0d APB transfers", size, xfers));
            end
        end

        exp_err  = 1'b1;
        exp_data = '1;
        mask     = '1;
        if (!last) begin
            assert (lat == 1) else begin
                fail_run($sformatf("Burst refusal came %0d cycles after acceptance", lat));
            end
            assert (!apb_seen) else begin
                fail_run("APB transfer started for a refused burst request");
            end
        end else if (!is_mapped(addr)) begin
            assert (lat == 3) else begin
                fail_run($sformatf("Unmapped response came %0d cycles after acceptance", lat));
            end
            check_hex("o_psel", psel_seen, '0);
        end else begin
            s = slave_of(addr);
            w = int'(addr[11:2]);
            if (size == 8'd8) begin
                exp_err  = (w + 1 >= 'h3fc);     // Second word decides
                exp_data = {model_mem[s][w+1], model_mem[s][w]};
                if (write) begin
                    store_word(s, w, wdata[31:0], wstrb[3:0]);
                    store_word(s, w + 1, wdata[63:32], wstrb[7:4]);
                end
            end else if (addr[2]) begin
                exp_err  = (w >= 'h3fc);
                exp_data = {model_mem[s][w], 32'h0};
                mask     = {32'hffff_ffff, 32'h0};
                if (write) begin
                    store_word(s, w, wdata[63:32], wstrb[7:4]);
                end
            end else begin
                exp_err  = (w >= 'h3fc);
                exp_data = {32'h0, model_mem[s][w]};
                mask     = {32'h0, 32'hffff_ffff};
                if (write) begin
                    store_word(s, w, wdata[31:0], wstrb[3:0]);
                end
            end
        end
        check_hex("o_resp_err", resp_err, exp_err);
        if (!write || !last || !is_mapped(addr)) begin
            check_hex("o_resp_rdata", resp_rdata & mask, exp_data & mask);
        end
    endtask

    initial begin
        apb_bridge_pkg::addr_t     addr;
        apb_bridge_pkg::req_size_t size;
        int                        kind;
        int                        s;
        int                        w;

        void'($urandom(32'hf853));
        clk       = 1'b0;
        nrst      = 1'b0;
        cycles    = 0;
        req_valid = 1'b0;
        req_addr  = '0;
        req_size  = 8'd4;
        req_write = 1'b0;
        req_wdata = '0;
        req_wstrb = '0;
        req_last  = 1'b1;
        for (s = 0; s < `APB_NUM_SLAVES; s++) begin
            for (w = 0; w < 1024; w++) begin
                model_mem[s][w] = fill_word(`APB_MAP_BASE + s * `APB_SLOT_SIZE + w * 4);
            end
        end

        for (int c = 0; c <= RESET_CYC; c++) begin
            @(posedge clk);
            if (c > 0) begin    // First edge only settles the reset
                check_hex("o_req_ready", req_ready, 1'b1);
                check_hex("o_resp_valid", resp_valid, 1'b0);
                check_hex("o_psel", psel, '0);
                check_hex("o_penable", penable, 1'b0);
            end
            if (c == RESET_CYC - 1) begin
                #1;
                nrst = 1'b1;
            end
        end

        for (int n = 0; n < NUM_REQS; n++) begin
            kind = $urandom % 10;
            s    = $urandom % `APB_NUM_SLAVES;
            w    = ($urandom % 2) ? ($urandom % 16) : ('h3f8 + $urandom % 8);
            size = ($urandom % 2) ? 8'd8 : 8'd4;
            if (size == 8'd8) begin
                w = w & ~1;     // 8-byte requests stay doubleword aligned
            end
            addr = `APB_MAP_BASE + s * `APB_SLOT_SIZE + w * 4;
            if (kind == 0) begin
                size = 8'd4;
                addr = ($urandom % 2) ? (`APB_MAP_BASE - 32'h100 + (w % 64) * 4)
                                      : (`APB_MAP_BASE + 3 * `APB_SLOT_SIZE + (w % 64) * 4);
            end
            run_request(addr, size, 1'($urandom), {$urandom, $urandom}, 8'($urandom), kind != 1);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+source
source/apb_bridge_pkg.sv
source/apb_master_if.sv
source/apb_addr_decoder.sv
source/apb_transfer_seq.sv
source/apb_slave_fabric.sv
source/apb_bridge_top.sv
verif/apb_slave_model.sv
verif/apb_bridge_tb.sv
